//--- cdma_shared_buffer.f
+incdir+include
hw/sbuf_addr_pkg.sv
hw/sbuf_data_pkg.sv
hw/sbuf_port_decode.sv
hw/sbuf_bank.sv
hw/sbuf_read_return.sv
hw/cdma_shared_buffer.sv
test/cdma_shared_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the shared buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  -f cdma_shared_buffer.f \
  --top-module cdma_shared_buffer_tb \
  -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vcdma_shared_buffer_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- test/cdma_shared_buffer_tb.sv
`timescale 1ns/1ps

module cdma_shared_buffer_tb;

  import sbuf_addr_pkg::*;
  import sbuf_data_pkg::*;

  localparam int MAX_ROWS     = 64;
  localparam int RESET_CYCLES = 10;
  // read sampled one edge after drive, port word loaded one edge later
  localparam int RETURN_LAG   = 2;

  logic       nvdla_core_clk;
  logic       reset;
  logic       p0_wr_en;
  sbuf_addr_t p0_wr_addr;
  sbuf_data_t p0_wr_data;
  logic       p1_wr_en;
  sbuf_addr_t p1_wr_addr;
  sbuf_data_t p1_wr_data;
  logic       p0_rd_en;
  sbuf_addr_t p0_rd_addr;
  sbuf_data_t p0_rd_data;
  logic       p1_rd_en;
  sbuf_addr_t p1_rd_addr;
  sbuf_data_t p1_rd_data;

  ////////////////////////////////////////////////////
  // stimulus table, one row per clock
  ////////////////////////////////////////////////////

  logic       tab_w0_en [MAX_ROWS];
  sbuf_addr_t tab_w0_addr [MAX_ROWS];
  sbuf_data_t tab_w0_data [MAX_ROWS];
  logic       tab_w1_en [MAX_ROWS];
  sbuf_addr_t tab_w1_addr [MAX_ROWS];
  sbuf_data_t tab_w1_data [MAX_ROWS];
  logic       tab_r0_en [MAX_ROWS];
  sbuf_addr_t tab_r0_addr [MAX_ROWS];
  logic       tab_r1_en [MAX_ROWS];
  sbuf_addr_t tab_r1_addr [MAX_ROWS];
  // expected port words, valid once the port has read at least once
  sbuf_data_t tab_exp0 [MAX_ROWS];
  sbuf_data_t tab_exp1 [MAX_ROWS];
  logic       tab_chk0 [MAX_ROWS];
  logic       tab_chk1 [MAX_ROWS];

  // reference memory, whole 8-bit word address space
  sbuf_data_t model_mem [256];
  sbuf_data_t hold_0;
  sbuf_data_t hold_1;
  logic       seen_0;
  logic       seen_1;
  logic [15:0] lfsr_state;
  int row_count;
  int err_count;
  int check_count;
  int cycle_count = 0;
  int cycle_limit = 0;

  cdma_shared_buffer cdma_shared_buffer_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .p0_wr_en       (p0_wr_en),
    .p0_wr_addr     (p0_wr_addr),
    .p0_wr_data     (p0_wr_data),
    .p1_wr_en       (p1_wr_en),
    .p1_wr_addr     (p1_wr_addr),
    .p1_wr_data     (p1_wr_data),
    .p0_rd_en       (p0_rd_en),
    .p0_rd_addr     (p0_rd_addr),
    .p0_rd_data     (p0_rd_data),
    .p1_rd_en       (p1_rd_en),
    .p1_rd_addr     (p1_rd_addr),
    .p1_rd_data     (p1_rd_data)
  );

  // 40 ns period
  always #20 nvdla_core_clk = ~nvdla_core_clk;

  // run guard
  always @(posedge nvdla_core_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per data bit
  task automatic rand_word(output sbuf_data_t w);
    w = '0;
    for (int b = 0; b < $bits(sbuf_data_t); b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[$bits(sbuf_data_t)-2:0], lfsr_state[0]};
    end
  endtask

  // bank in the top 3 bits, entry in the low 5
  function automatic sbuf_addr_t addr_of(input int bank, input int entry);
    return sbuf_addr_t'(bank * 32 + entry);
  endfunction

  task automatic add_row(input logic w0e, input sbuf_addr_t w0a,
                         input logic w1e, input sbuf_addr_t w1a,
                         input logic r0e, input sbuf_addr_t r0a,
                         input logic r1e, input sbuf_addr_t r1a);
    sbuf_data_t d0;
    sbuf_data_t d1;
    int r;
    r = row_count;
    d0 = '0;
    d1 = '0;
    if (w0e) rand_word(d0);
    if (w1e) rand_word(d1);
    // reads see the model before this row's writes
    if (r0e) begin
      hold_0 = model_mem[r0a];
      seen_0 = 1'b1;
    end
    if (r1e) begin
      hold_1 = model_mem[r1a];
      seen_1 = 1'b1;
    end
    tab_exp0[r] = hold_0;
    tab_chk0[r] = seen_0;
    tab_exp1[r] = hold_1;
    tab_chk1[r] = seen_1;
    if (w0e) model_mem[w0a] = d0;
    if (w1e) model_mem[w1a] = d1;
    tab_w0_en[r] = w0e;
    tab_w0_addr[r] = w0a;
    tab_w0_data[r] = d0;
    tab_w1_en[r] = w1e;
    tab_w1_addr[r] = w1a;
    tab_w1_data[r] = d1;
    tab_r0_en[r] = r0e;
    tab_r0_addr[r] = r0a;
    tab_r1_en[r] = r1e;
    tab_r1_addr[r] = r1a;
    row_count = row_count + 1;
  endtask

  task automatic build_table();
    // every bank at entries 0 and 31 through p0, read back on p1 one row behind
    for (int i = 0; i <= 16; i++) begin
      int k;
      k = (i > 0) ? i - 1 : 0;
      add_row(i < 16, addr_of(i / 2, (i % 2) * 31), 1'b0, '0,
              1'b0, '0, i > 0, addr_of(k / 2, (k % 2) * 31));
    end
    // both ports write, different banks
    add_row(1'b1, addr_of(1, 5), 1'b1, addr_of(6, 9), 1'b0, '0, 1'b0, '0);
    add_row(1'b1, addr_of(3, 12), 1'b1, addr_of(4, 20), 1'b0, '0, 1'b0, '0);
    // both ports read back to back, two in flight each
    add_row(1'b1, addr_of(2, 7), 1'b0, '0, 1'b1, addr_of(6, 9), 1'b1, addr_of(1, 5));
    add_row(1'b0, '0, 1'b0, '0, 1'b1, addr_of(4, 20), 1'b1, addr_of(3, 12));
    add_row(1'b0, '0, 1'b0, '0, 1'b1, addr_of(0, 0), 1'b1, addr_of(7, 31));
    add_row(1'b0, '0, 1'b0, '0, 1'b1, addr_of(2, 31), 1'b1, addr_of(5, 0));
    // p0 idle, holds its word
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1, addr_of(1, 0));
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1, addr_of(3, 31));
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1, addr_of(6, 0));
    // p1 idle
    add_row(1'b0, '0, 1'b0, '0, 1'b1, addr_of(4, 0), 1'b0, '0);
    add_row(1'b0, '0, 1'b0, '0, 1'b1, addr_of(7, 0), 1'b0, '0);
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    // read-first, old word then new
    add_row(1'b0, '0, 1'b1, addr_of(2, 7), 1'b1, addr_of(2, 7), 1'b0, '0);
    add_row(1'b0, '0, 1'b0, '0, 1'b1, addr_of(2, 7), 1'b0, '0);
    add_row(1'b1, addr_of(5, 31), 1'b0, '0, 1'b0, '0, 1'b1, addr_of(5, 31));
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1, addr_of(5, 31));
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    add_row(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic drive_row(input int r);
    p0_wr_en   <= tab_w0_en[r];
    p0_wr_addr <= tab_w0_addr[r];
    p0_wr_data <= tab_w0_data[r];
    p1_wr_en   <= tab_w1_en[r];
    p1_wr_addr <= tab_w1_addr[r];
    p1_wr_data <= tab_w1_data[r];
    p0_rd_en   <= tab_r0_en[r];
    p0_rd_addr <= tab_r0_addr[r];
    p1_rd_en   <= tab_r1_en[r];
    p1_rd_addr <= tab_r1_addr[r];
  endtask

  task automatic drive_idle();
    p0_wr_en <= 1'b0;
    p1_wr_en <= 1'b0;
    p0_rd_en <= 1'b0;
    p1_rd_en <= 1'b0;
  endtask

  task automatic check_value(input string name, input sbuf_data_t actual,
                             input sbuf_data_t expected);
    check_count = check_count + 1;
    if (actual !== expected) begin
      err_count = err_count + 1;
      $display("Error at time %0t: %s expected %h, actual %h",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_row(input int r);
    if (tab_chk0[r]) check_value("p0_rd_data", p0_rd_data, tab_exp0[r]);
    if (tab_chk1[r]) check_value("p1_rd_data", p1_rd_data, tab_exp1[r]);
  endtask

  ////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////

  initial begin
    nvdla_core_clk = 1'b0;
    reset = 1'b1;
    p0_wr_en = 1'b0;
    p0_wr_addr = '0;
    p0_wr_data = '0;
    p1_wr_en = 1'b0;
    p1_wr_addr = '0;
    p1_wr_data = '0;
    p0_rd_en = 1'b0;
    p0_rd_addr = '0;
    p1_rd_en = 1'b0;
    p1_rd_addr = '0;
    lfsr_state = 16'd31;
    row_count = 0;
    err_count = 0;
    check_count = 0;
    seen_0 = 1'b0;
    seen_1 = 1'b0;
    hold_0 = '0;
    hold_1 = '0;
    build_table();
    // rows, reset, drain and margin
    cycle_limit = row_count + RESET_CYCLES + 4 + 20;

    repeat (RESET_CYCLES) @(posedge nvdla_core_clk);
    reset <= 1'b0;

    // drive on the rising edge, check on the falling edge
    for (int i = 0; i < row_count + RETURN_LAG; i++) begin
      @(posedge nvdla_core_clk);
      if (i < row_count) drive_row(i);
      else drive_idle();
      @(negedge nvdla_core_clk);
      if (i >= RETURN_LAG) check_row(i - RETURN_LAG);
    end

    $display("checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- hw/cdma_shared_buffer.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module cdma_shared_buffer (
  input  logic                      nvdla_core_clk,
  input  logic                      reset,
  input  logic                      p0_wr_en,
  input  sbuf_addr_pkg::sbuf_addr_t p0_wr_addr,
  input  sbuf_data_pkg::sbuf_data_t p0_wr_data,
  input  logic                      p1_wr_en,
  input  sbuf_addr_pkg::sbuf_addr_t p1_wr_addr,
  input  sbuf_data_pkg::sbuf_data_t p1_wr_data,
  input  logic                      p0_rd_en,
  input  sbuf_addr_pkg::sbuf_addr_t p0_rd_addr,
  output sbuf_data_pkg::sbuf_data_t p0_rd_data,
  input  logic                      p1_rd_en,
  input  sbuf_addr_pkg::sbuf_addr_t p1_rd_addr,
  output sbuf_data_pkg::sbuf_data_t p1_rd_data
);

  // per-bank controls out of the decoder
  sbuf_addr_pkg::sbuf_bank_vec_t bank_we;
  sbuf_addr_pkg::sbuf_bank_vec_t bank_re;
  sbuf_addr_pkg::sbuf_entry_t    bank_wa [`SBUF_BANK_NUM];
  sbuf_addr_pkg::sbuf_entry_t    bank_ra [`SBUF_BANK_NUM];
  sbuf_data_pkg::sbuf_data_t     bank_wdat [`SBUF_BANK_NUM];

  // port read selects, one-hot over banks
  sbuf_addr_pkg::sbuf_bank_vec_t p0_rd_sel;
  sbuf_addr_pkg::sbuf_bank_vec_t p1_rd_sel;

  // registered bank words
  sbuf_data_pkg::sbuf_data_t     bank_rdat [`SBUF_BANK_NUM];

  //////////////////////////////////////////////////
  // ports to banks
  //////////////////////////////////////////////////

  sbuf_port_decode u_decode (
    .p0_wr_en   (p0_wr_en),
    .p0_wr_addr (p0_wr_addr),
    .p0_wr_data (p0_wr_data),
    .p1_wr_en   (p1_wr_en),
    .p1_wr_addr (p1_wr_addr),
    .p1_wr_data (p1_wr_data),
    .p0_rd_en   (p0_rd_en),
    .p0_rd_addr (p0_rd_addr),
    .p1_rd_en   (p1_rd_en),
    .p1_rd_addr (p1_rd_addr),
    .bank_we    (bank_we),
    .bank_wa    (bank_wa),
    .bank_wdat  (bank_wdat),
    .bank_re    (bank_re),
    .bank_ra    (bank_ra),
    .p0_rd_sel  (p0_rd_sel),
    .p1_rd_sel  (p1_rd_sel)
  );

  //////////////////////////////////////////////////
  // bank array
  //////////////////////////////////////////////////

  for (genvar b = 0; b < `SBUF_BANK_NUM; b++) begin : g_bank
    sbuf_bank u_bank (
      .nvdla_core_clk (nvdla_core_clk),
      .we             (bank_we[b]),
      .wa             (bank_wa[b]),
      .di             (bank_wdat[b]),
      .re             (bank_re[b]),
      .ra             (bank_ra[b]),
      .dout           (bank_rdat[b])
    );
  end

  //////////////////////////////////////////////////
  // banks back to ports, two cycles
  //////////////////////////////////////////////////

  sbuf_read_return u_return (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .p0_rd_en       (p0_rd_en),
    .p0_rd_sel      (p0_rd_sel),
    .p1_rd_en       (p1_rd_en),
    .p1_rd_sel      (p1_rd_sel),
    .bank_rdat      (bank_rdat),
    .p0_rd_data     (p0_rd_data),
    .p1_rd_data     (p1_rd_data)
  );

endmodule

//--- hw/sbuf_read_return.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module sbuf_read_return (
  input  logic                          nvdla_core_clk,
  input  logic                          reset,
  input  logic                          p0_rd_en,
  input  sbuf_addr_pkg::sbuf_bank_vec_t p0_rd_sel,
  input  logic                          p1_rd_en,
  input  sbuf_addr_pkg::sbuf_bank_vec_t p1_rd_sel,
  input  sbuf_data_pkg::sbuf_data_t     bank_rdat [`SBUF_BANK_NUM],
  output sbuf_data_pkg::sbuf_data_t     p0_rd_data,
  output sbuf_data_pkg::sbuf_data_t     p1_rd_data
);

  import sbuf_addr_pkg::*;
  import sbuf_data_pkg::*;

  sbuf_bank_vec_t p0_sel_d1;
  sbuf_bank_vec_t p1_sel_d1;
  logic           p0_rd_en_d1;
  logic           p1_rd_en_d1;
  sbuf_data_t     p0_rdat;
  sbuf_data_t     p1_rdat;

  // and-or pick of the bank word flagged in sel
  function automatic sbuf_data_t bank_mux(input sbuf_bank_vec_t sel,
                                          input sbuf_data_t rdat [`SBUF_BANK_NUM]);
    sbuf_data_t acc;
    acc = '0;
    for (int b = 0; b < `SBUF_BANK_NUM; b++) begin
      acc = acc | ({`SBUF_DATA_BITS{sel[b]}} & rdat[b]);
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////
  // stage 1, track which bank answers
  //////////////////////////////////////////////////

  // captured on the same edge the bank samples its read
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      p0_sel_d1   <= '0;
      p1_sel_d1   <= '0;
      p0_rd_en_d1 <= 1'b0;
      p1_rd_en_d1 <= 1'b0;
    end else begin
      p0_sel_d1   <= p0_rd_sel;
      p1_sel_d1   <= p1_rd_sel;
      p0_rd_en_d1 <= p0_rd_en;
      p1_rd_en_d1 <= p1_rd_en;
    end
  end

  //////////////////////////////////////////////////
  // stage 2, bank mux and port output register
  //////////////////////////////////////////////////

  assign p0_rdat = bank_mux(p0_sel_d1, bank_rdat);
  assign p1_rdat = bank_mux(p1_sel_d1, bank_rdat);

  // loads only on a returning read, holds otherwise
  always_ff @(posedge nvdla_core_clk) begin
    if (p0_rd_en_d1) begin
      p0_rd_data <= p0_rdat;
    end
    if (p1_rd_en_d1) begin
      p1_rd_data <= p1_rdat;
    end
  end

endmodule

//--- hw/sbuf_bank.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module sbuf_bank (
  input  logic                       nvdla_core_clk,
  input  logic                       we,
  input  sbuf_addr_pkg::sbuf_entry_t wa,
  input  sbuf_data_pkg::sbuf_data_t  di,
  input  logic                       re,
  input  sbuf_addr_pkg::sbuf_entry_t ra,
  output sbuf_data_pkg::sbuf_data_t  dout
);

  import sbuf_addr_pkg::*;
  import sbuf_data_pkg::*;

  // 32 words per bank
  sbuf_data_t mem [2**`SBUF_ENTRY_BITS];

  //////////////////////////////////////////////////
  // one write and one read per cycle
  //////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk) begin
    if (we) begin
      mem[wa] <= di;
    end
    // read-first, same-entry write lands after the sample
    // dout holds while no read
    if (re) begin
      dout <= mem[ra];
    end
  end

endmodule

//--- hw/sbuf_port_decode.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module sbuf_port_decode (
  input  logic                          p0_wr_en,
  input  sbuf_addr_pkg::sbuf_addr_t     p0_wr_addr,
  input  sbuf_data_pkg::sbuf_data_t     p0_wr_data,
  input  logic                          p1_wr_en,
  input  sbuf_addr_pkg::sbuf_addr_t     p1_wr_addr,
  input  sbuf_data_pkg::sbuf_data_t     p1_wr_data,
  input  logic                          p0_rd_en,
  input  sbuf_addr_pkg::sbuf_addr_t     p0_rd_addr,
  input  logic                          p1_rd_en,
  input  sbuf_addr_pkg::sbuf_addr_t     p1_rd_addr,
  output sbuf_addr_pkg::sbuf_bank_vec_t bank_we,
  output sbuf_addr_pkg::sbuf_entry_t    bank_wa [`SBUF_BANK_NUM],
  output sbuf_data_pkg::sbuf_data_t     bank_wdat [`SBUF_BANK_NUM],
  output sbuf_addr_pkg::sbuf_bank_vec_t bank_re,
  output sbuf_addr_pkg::sbuf_entry_t    bank_ra [`SBUF_BANK_NUM],
  output sbuf_addr_pkg::sbuf_bank_vec_t p0_rd_sel,
  output sbuf_addr_pkg::sbuf_bank_vec_t p1_rd_sel
);

  import sbuf_addr_pkg::*;
  import sbuf_data_pkg::*;

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////

  sbuf_bank_sel_t p0_wr_bsel;
  sbuf_bank_sel_t p1_wr_bsel;
  sbuf_bank_sel_t p0_rd_bsel;
  sbuf_bank_sel_t p1_rd_bsel;
  sbuf_entry_t    p0_wr_esel;
  sbuf_entry_t    p1_wr_esel;
  sbuf_entry_t    p0_rd_esel;
  sbuf_entry_t    p1_rd_esel;
  sbuf_bank_vec_t p0_wr_sel;
  sbuf_bank_vec_t p1_wr_sel;

  // bank number from the top bits
  assign p0_wr_bsel = p0_wr_addr[`SBUF_ADDR_BITS-1 -: `SBUF_BANK_BITS];
  assign p1_wr_bsel = p1_wr_addr[`SBUF_ADDR_BITS-1 -: `SBUF_BANK_BITS];
  assign p0_rd_bsel = p0_rd_addr[`SBUF_ADDR_BITS-1 -: `SBUF_BANK_BITS];
  assign p1_rd_bsel = p1_rd_addr[`SBUF_ADDR_BITS-1 -: `SBUF_BANK_BITS];

  // entry from the bottom bits
  assign p0_wr_esel = p0_wr_addr[`SBUF_ENTRY_BITS-1:0];
  assign p1_wr_esel = p1_wr_addr[`SBUF_ENTRY_BITS-1:0];
  assign p0_rd_esel = p0_rd_addr[`SBUF_ENTRY_BITS-1:0];
  assign p1_rd_esel = p1_rd_addr[`SBUF_ENTRY_BITS-1:0];

  //////////////////////////////////////////////////
  // per-bank selects and merge
  //////////////////////////////////////////////////

  for (genvar b = 0; b < `SBUF_BANK_NUM; b++) begin : g_bank
    // one-hot selects, zero when the port is idle
    assign p0_wr_sel[b] = p0_wr_en & (p0_wr_bsel == sbuf_bank_sel_t'(b));
    assign p1_wr_sel[b] = p1_wr_en & (p1_wr_bsel == sbuf_bank_sel_t'(b));
    assign p0_rd_sel[b] = p0_rd_en & (p0_rd_bsel == sbuf_bank_sel_t'(b));
    assign p1_rd_sel[b] = p1_rd_en & (p1_rd_bsel == sbuf_bank_sel_t'(b));

    // write side, and-or merge of both ports
    // both ports on one bank in a cycle is not allowed
    assign bank_we[b]   = p0_wr_sel[b] | p1_wr_sel[b];
    assign bank_wa[b]   = ({`SBUF_ENTRY_BITS{p0_wr_sel[b]}} & p0_wr_esel) |
                          ({`SBUF_ENTRY_BITS{p1_wr_sel[b]}} & p1_wr_esel);
    assign bank_wdat[b] = ({`SBUF_DATA_BITS{p0_wr_sel[b]}} & p0_wr_data) |
                          ({`SBUF_DATA_BITS{p1_wr_sel[b]}} & p1_wr_data);

    // read side, same merge
    assign bank_re[b]   = p0_rd_sel[b] | p1_rd_sel[b];
    assign bank_ra[b]   = ({`SBUF_ENTRY_BITS{p0_rd_sel[b]}} & p0_rd_esel) |
                          ({`SBUF_ENTRY_BITS{p1_rd_sel[b]}} & p1_rd_esel);
  end

endmodule

//--- hw/sbuf_data_pkg.sv
`include "sbuf_config.svh"

package sbuf_data_pkg;

  //////////////////////////////////////////////////
  // data words
  //////////////////////////////////////////////////

  // one buffer word
  // same width on write data, bank output and port read data
  // per-bank arrays of this type carry write data into the banks
  // and registered bank words back to the read return
  typedef logic [`SBUF_DATA_BITS-1:0] sbuf_data_t;

endpackage

//--- hw/sbuf_addr_pkg.sv
`include "sbuf_config.svh"

package sbuf_addr_pkg;

  //////////////////////////////////////////////////
  // address fields
  //////////////////////////////////////////////////

  // full word address as driven by a client
  typedef logic [`SBUF_ADDR_BITS-1:0] sbuf_addr_t;

  // bank number, upper slice of the address
  typedef logic [`SBUF_BANK_BITS-1:0] sbuf_bank_sel_t;

  // entry within one bank, lower slice
  typedef logic [`SBUF_ENTRY_BITS-1:0] sbuf_entry_t;

  // one bit per bank
  // write enables, read enables, one-hot port selects
  typedef logic [`SBUF_BANK_NUM-1:0] sbuf_bank_vec_t;

endpackage

//--- include/sbuf_config.svh
`ifndef SBUF_CONFIG_SVH
`define SBUF_CONFIG_SVH

//////////////////////////////////////////////////
// shared buffer geometry
//////////////////////////////////////////////////

// word address seen on each port
`define SBUF_ADDR_BITS 8

// upper address bits pick the bank
`define SBUF_BANK_BITS 3

// lower address bits pick the entry inside a bank
`define SBUF_ENTRY_BITS 5

// must equal 2**SBUF_BANK_BITS
`define SBUF_BANK_NUM 8

// one buffer word
`define SBUF_DATA_BITS 64

`endif
